/* common/vdma_axi_pkg.sv */
`default_nettype none

package vdma_axi_pkg;

	// ----------------------------------------------------------------------
	// bus geometry
	// ----------------------------------------------------------------------
	localparam int axi_addr_width = 32;
	localparam int axi_data_size  = 2;
	localparam int axi_data_width = 8 << axi_data_size;
	localparam int axi_len_width  = 8;

	// ----------------------------------------------------------------------
	// fixed burst attributes
	// ----------------------------------------------------------------------
	localparam logic [1:0] axi_burst_incr = 2'b01;
	localparam logic [2:0] axi_arsize     = 3'(axi_data_size);

	// bursts allowed in flight at once
	localparam int axi_max_outstanding   = 4;
	localparam int axi_outstanding_width = $clog2(axi_max_outstanding + 1);

	// one stream beat with its sideband bits
	typedef struct packed {
		logic [axi_data_width-1:0] data;
		logic                      last;
		logic                      user;
	} stream_beat_t;

endpackage

`default_nettype wire

/* common/vdma_frame_pkg.sv */
`default_nettype none

package vdma_frame_pkg;
	import vdma_axi_pkg::*;

	// 16 bit pixels
	localparam int pixel_size   = 1;
	localparam int stride_width = 14;
	localparam int h_width      = 12;
	localparam int v_width      = 12;
	localparam int size_width   = 24;
	localparam int index_width  = 8;

	// two pixels per beat
	localparam int pix_beat_shift = axi_data_size - pixel_size;

	typedef struct packed {
		logic [axi_addr_width-1:0] addr;
		logic [stride_width-1:0]   stride;
		logic [h_width-1:0]        width;
		logic [v_width-1:0]        height;
		logic [size_width-1:0]     size;
		logic [axi_len_width-1:0]  arlen;
	} frame_param_t;

	function automatic logic [size_width-1:0] pixels_to_beats(
		input logic [size_width-1:0] pixels
	);
		return pixels >> pix_beat_shift;
	endfunction

	function automatic logic [axi_addr_width-1:0] pixels_to_bytes(
		input logic [size_width-1:0] pixels
	);
		return axi_addr_width'(pixels) << pixel_size;
	endfunction

endpackage

`default_nettype wire

/* common/vdma_ifs.sv */
`default_nettype none

// one line (or one packed frame) handed from sequencer to reader
interface line_cmd_if
	import vdma_axi_pkg::*, vdma_frame_pkg::*;
();
	logic                      start;
	logic [axi_addr_width-1:0] addr;
	logic [size_width-1:0]     count;
	logic [size_width-1:0]     unit;
	logic [axi_len_width-1:0]  maxlen;

	// status back from the reader, all single cycle pulses but busy
	logic                      busy;
	logic                      ar_accept;
	logic                      r_last_accept;
	logic                      beat_taken;

	modport controller (
		output start, addr, count, unit, maxlen,
		input  busy, ar_accept, r_last_accept, beat_taken
	);

	modport reader (
		input  start, addr, count, unit, maxlen,
		output busy, ar_accept, r_last_accept, beat_taken
	);
endinterface

interface pixel_stream_if
	import vdma_axi_pkg::*;
();
	stream_beat_t beat;
	logic         valid;
	logic         ready;

	modport source (output beat, valid, input ready);
	modport sink   (input beat, valid, output ready);
endinterface

`default_nettype wire

/* design/stream_skid_buffer.sv */
`default_nettype none

module stream_skid_buffer
	import vdma_axi_pkg::*;
#(
	parameter type payload_t = stream_beat_t
)
(
	input  logic          aclk,
	input  logic          aresetn,
	pixel_stream_if.sink  in,
	output payload_t      m_payload,
	output logic          m_valid,
	input  logic          m_ready
);

	payload_t skid_payload;
	logic     skid_valid;
	logic     in_ready;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			m_valid    <= 1'b0;
			skid_valid <= 1'b0;
			in_ready   <= 1'b0;
		end else if (in_ready) begin
			if (!m_valid || m_ready) begin
				m_valid <= in.valid;
			end else if (in.valid) begin
				// output stalled, park the beat
				skid_valid <= 1'b1;
				in_ready   <= 1'b0;
			end
		end else if (!m_valid || m_ready) begin
			// drain skid into the output register
			m_valid    <= skid_valid;
			skid_valid <= 1'b0;
			in_ready   <= 1'b1;
		end
	end

	always_ff @(posedge aclk) begin
		if (in_ready) begin
			if (!m_valid || m_ready) begin
				m_payload <= in.beat;
			end else begin
				skid_payload <= in.beat;
			end
		end else if (!m_valid || m_ready) begin
			m_payload <= skid_payload;
		end
	end

	assign in.ready = in_ready;

endmodule

`default_nettype wire

/* vdma_read/vdma_read_control.sv */
`default_nettype none

module vdma_read_control
	import vdma_axi_pkg::*, vdma_frame_pkg::*;
(
	input  logic                   aclk,
	input  logic                   aresetn,
	input  logic                   ctl_enable,
	input  logic                   ctl_update,
	output logic                   ctl_busy,
	output logic [index_width-1:0] ctl_index,
	input  frame_param_t           param_in,
	output frame_param_t           monitor_param,
	line_cmd_if.controller         cmd,
	output logic                   frame_user
);

	frame_param_t                     shadow;
	frame_param_t                     next_param;
	logic                             packed_mode;
	logic                             frame_go;
	logic                             line_done;
	logic                             ar_active;
	logic                             start;
	logic [v_width-1:0]               lines_left;
	logic [axi_addr_width-1:0]        line_addr;
	logic [size_width-1:0]            line_count;
	logic [axi_outstanding_width-1:0] outstanding;

	// ----------------------------------------------------------------------
	// frame setup
	// ----------------------------------------------------------------------

	// parameters the coming frame will run with
	assign next_param = ctl_update ? param_in : shadow;

	// whole frame contiguous, read it as one transfer
	assign packed_mode = (next_param.size != '0) &&
		(pixels_to_bytes(size_width'(next_param.width)) ==
		axi_addr_width'(next_param.stride));

	assign frame_go  = !ctl_busy && ctl_enable;
	// reader idle again after the last command
	assign line_done = ar_active && !start && !cmd.busy;

	// ----------------------------------------------------------------------
	// sequencer
	// ----------------------------------------------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			ctl_busy    <= 1'b0;
			ctl_index   <= '0;
			start       <= 1'b0;
			ar_active   <= 1'b0;
			frame_user  <= 1'b0;
			outstanding <= '0;
		end else begin
			start       <= 1'b0;
			outstanding <= outstanding
				+ axi_outstanding_width'(cmd.ar_accept)
				- axi_outstanding_width'(cmd.r_last_accept);

			// user stays up until the first beat leaves the reader
			if (cmd.beat_taken) begin
				frame_user <= 1'b0;
			end

			if (frame_go) begin
				ctl_busy   <= 1'b1;
				ctl_index  <= ctl_index + 1'b1;
				start      <= 1'b1;
				ar_active  <= 1'b1;
				frame_user <= 1'b1;
			end else if (line_done) begin
				if (lines_left <= 1) begin
					ar_active <= 1'b0;
				end else begin
					start <= 1'b1;
				end
			end else if (ctl_busy && !ar_active && !start && !cmd.busy &&
				outstanding == '0) begin
				ctl_busy <= 1'b0;
			end
		end
	end

	// shadow set and line stepping
	always_ff @(posedge aclk) begin
		if (frame_go) begin
			if (ctl_update) begin
				shadow <= param_in;
			end
			line_addr <= next_param.addr;
			if (packed_mode) begin
				line_count <= pixels_to_beats(next_param.size);
				lines_left <= v_width'(1);
			end else begin
				line_count <= pixels_to_beats(size_width'(next_param.width));
				lines_left <= next_param.height;
			end
		end else if (line_done && lines_left > 1) begin
			line_addr  <= line_addr + axi_addr_width'(shadow.stride);
			lines_left <= lines_left - 1'b1;
		end
	end

	assign cmd.start  = start;
	assign cmd.addr   = line_addr;
	assign cmd.count  = line_count;
	// tlast spacing is always one line
	assign cmd.unit   = pixels_to_beats(size_width'(shadow.width));
	assign cmd.maxlen = shadow.arlen;

	assign monitor_param = shadow;

endmodule

`default_nettype wire

/* vdma_read/axi4_line_reader.sv */
`default_nettype none

module axi4_line_reader
	import vdma_axi_pkg::*, vdma_frame_pkg::*;
(
	input  logic                      aclk,
	input  logic                      aresetn,
	line_cmd_if.reader                cmd,
	input  logic                      frame_user,
	output logic [axi_addr_width-1:0] araddr,
	output logic [axi_len_width-1:0]  arlen,
	output logic [2:0]                arsize,
	output logic [1:0]                arburst,
	output logic                      arvalid,
	input  logic                      arready,
	input  logic [axi_data_width-1:0] rdata,
	input  logic                      rlast,
	input  logic                      rvalid,
	output logic                      rready,
	pixel_stream_if.source            out
);

	logic                             busy;
	logic                             launch;
	logic                             ar_hs;
	logic                             r_hs;
	logic                             unit_end;
	logic [size_width-1:0]            remain;
	logic [size_width-1:0]            max_beats;
	logic [size_width-1:0]            burst_beats;
	logic [size_width-1:0]            unit_count;
	logic [axi_outstanding_width-1:0] in_flight;

	// ----------------------------------------------------------------------
	// AR channel
	// ----------------------------------------------------------------------
	assign ar_hs  = arvalid && arready;
	assign launch = busy && !arvalid && (in_flight < axi_max_outstanding);

	assign max_beats   = size_width'(cmd.maxlen) + 1'b1;
	assign burst_beats = (remain > max_beats) ? max_beats : remain;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			busy      <= 1'b0;
			arvalid   <= 1'b0;
			in_flight <= '0;
		end else begin
			in_flight <= in_flight
				+ axi_outstanding_width'(ar_hs)
				- axi_outstanding_width'(r_hs && rlast);

			if (cmd.start) begin
				busy <= (cmd.count != '0);
			end else if (ar_hs && remain == '0) begin
				// last burst of the command accepted
				busy <= 1'b0;
			end

			if (ar_hs) begin
				arvalid <= 1'b0;
			end else if (launch) begin
				arvalid <= 1'b1;
			end
		end
	end

	// burst address and length
	always_ff @(posedge aclk) begin
		if (cmd.start) begin
			araddr <= cmd.addr;
			remain <= cmd.count;
		end else begin
			if (launch) begin
				arlen  <= axi_len_width'(burst_beats - 1'b1);
				remain <= remain - burst_beats;
			end
			if (ar_hs) begin
				araddr <= araddr + ((axi_addr_width'(arlen) + 1'b1) << axi_data_size);
			end
		end
	end

	assign arsize  = axi_arsize;
	assign arburst = axi_burst_incr;

	// ----------------------------------------------------------------------
	// R channel to stream
	// ----------------------------------------------------------------------
	assign r_hs     = rvalid && out.ready;
	assign unit_end = (unit_count == cmd.unit - 1'b1);

	// beat position within the current line
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			unit_count <= '0;
		end else if (r_hs) begin
			unit_count <= unit_end ? '0 : unit_count + 1'b1;
		end
	end

	assign out.valid     = rvalid;
	assign out.beat.data = rdata;
	assign out.beat.last = unit_end;
	assign out.beat.user = frame_user;
	assign rready        = out.ready;

	assign cmd.busy          = busy;
	assign cmd.ar_accept     = ar_hs;
	assign cmd.r_last_accept = r_hs && rlast;
	assign cmd.beat_taken    = r_hs;

endmodule

`default_nettype wire

/* design/vdma_read_top.sv */
`default_nettype none

module vdma_read_top
	import vdma_axi_pkg::*, vdma_frame_pkg::*;
(
	input  logic                      aclk,
	input  logic                      aresetn,

	// host control
	input  logic                      ctl_enable,
	input  logic                      ctl_update,
	output logic                      ctl_busy,
	output logic [index_width-1:0]    ctl_index,

	// frame parameters
	input  logic [axi_addr_width-1:0] param_addr,
	input  logic [stride_width-1:0]   param_stride,
	input  logic [h_width-1:0]        param_width,
	input  logic [v_width-1:0]        param_height,
	input  logic [size_width-1:0]     param_size,
	input  logic [axi_len_width-1:0]  param_arlen,
	output frame_param_t              monitor_param,

	// AXI4 read master
	output logic [axi_addr_width-1:0] m_axi_araddr,
	output logic [axi_len_width-1:0]  m_axi_arlen,
	output logic [2:0]                m_axi_arsize,
	output logic [1:0]                m_axi_arburst,
	output logic                      m_axi_arvalid,
	input  logic                      m_axi_arready,
	input  logic [axi_data_width-1:0] m_axi_rdata,
	input  logic                      m_axi_rlast,
	input  logic                      m_axi_rvalid,
	output logic                      m_axi_rready,

	// AXI4-Stream pixel output
	output logic [axi_data_width-1:0] m_axis_tdata,
	output logic                      m_axis_tlast,
	output logic                      m_axis_tuser,
	output logic                      m_axis_tvalid,
	input  logic                      m_axis_tready
);

	frame_param_t param_in;
	stream_beat_t axis_beat;
	logic         frame_user;

	line_cmd_if     cmd_if ();
	pixel_stream_if pix_if ();

	assign param_in.addr   = param_addr;
	assign param_in.stride = param_stride;
	assign param_in.width  = param_width;
	assign param_in.height = param_height;
	assign param_in.size   = param_size;
	assign param_in.arlen  = param_arlen;

	vdma_read_control u_control (
		.aclk          (aclk),
		.aresetn       (aresetn),
		.ctl_enable    (ctl_enable),
		.ctl_update    (ctl_update),
		.ctl_busy      (ctl_busy),
		.ctl_index     (ctl_index),
		.param_in      (param_in),
		.monitor_param (monitor_param),
		.cmd           (cmd_if.controller),
		.frame_user    (frame_user)
	);

	axi4_line_reader u_reader (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.cmd        (cmd_if.reader),
		.frame_user (frame_user),
		.araddr     (m_axi_araddr),
		.arlen      (m_axi_arlen),
		.arsize     (m_axi_arsize),
		.arburst    (m_axi_arburst),
		.arvalid    (m_axi_arvalid),
		.arready    (m_axi_arready),
		.rdata      (m_axi_rdata),
		.rlast      (m_axi_rlast),
		.rvalid     (m_axi_rvalid),
		.rready     (m_axi_rready),
		.out        (pix_if.source)
	);

	// output register stage
	stream_skid_buffer #(
		.payload_t (stream_beat_t)
	) u_skid (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.in        (pix_if.sink),
		.m_payload (axis_beat),
		.m_valid   (m_axis_tvalid),
		.m_ready   (m_axis_tready)
	);

	assign m_axis_tdata = axis_beat.data;
	assign m_axis_tlast = axis_beat.last;
	assign m_axis_tuser = axis_beat.user;

endmodule

`default_nettype wire

/* bench/axi4_read_mem_model.sv */
`default_nettype none

module axi4_read_mem_model
	import vdma_axi_pkg::*;
#(
	parameter logic [axi_data_width-1:0] data_key = 32'h5a3c_96e1
)
(
	input  logic                      aclk,
	input  logic                      aresetn,
	input  logic [axi_addr_width-1:0] araddr,
	input  logic [axi_len_width-1:0]  arlen,
	input  logic                      arvalid,
	output logic                      arready,
	output logic [axi_data_width-1:0] rdata,
	output logic                      rlast,
	output logic                      rvalid,
	input  logic                      rready
);
	timeunit 1ns;
	timeprecision 1ps;

	// accepted bursts waiting for their data phase
	logic [axi_addr_width-1:0] addr_q [$];
	logic [axi_len_width-1:0]  len_q [$];
	logic [axi_addr_width-1:0] beat_addr;
	logic [axi_len_width-1:0]  beats_left;
	logic                      active;
	logic [31:0]               rng;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	initial begin
		arready = 1'b0;
		rvalid  = 1'b0;
		rlast   = 1'b0;
		rdata   = '0;
		active  = 1'b0;
		rng     = 32'd63;
	end

	always @(posedge aclk) begin
		if (!aresetn) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rlast   <= 1'b0;
			active = 1'b0;
			addr_q.delete();
			len_q.delete();
		end else begin
			rng = xorshift32(rng);
			if (arvalid && arready) begin
				addr_q.push_back(araddr);
				len_q.push_back(arlen);
			end
			// about one cycle in four without arready
			arready <= (rng[1:0] != 2'b00);

			if (rvalid && rready) begin
				if (rlast) begin
					active = 1'b0;
				end else begin
					beat_addr  = beat_addr + (1 << axi_data_size);
					beats_left = beats_left - 1'b1;
				end
			end
			if (!active && addr_q.size() != 0) begin
				active     = 1'b1;
				beat_addr  = addr_q.pop_front();
				beats_left = len_q.pop_front();
			end

			// a beat not yet taken stays as it is
			if (!rvalid || rready) begin
				if (active && rng[4:2] > 3'd1) begin
					rvalid <= 1'b1;
					rdata  <= beat_addr ^ data_key;
					rlast  <= (beats_left == '0);
				end else begin
					rvalid <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* bench/tb_vdma_read.sv */
`default_nettype none

module tb_vdma_read
	import vdma_axi_pkg::*, vdma_frame_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] data_key    = 32'h5a3c_96e1;
	localparam int          frame_count = 12;
	localparam int          wait_limit  = 4000;

	logic                      aclk;
	logic                      aresetn;
	logic                      ctl_enable;
	logic                      ctl_update;
	logic                      ctl_busy;
	logic [index_width-1:0]    ctl_index;
	logic [axi_addr_width-1:0] param_addr;
	logic [stride_width-1:0]   param_stride;
	logic [h_width-1:0]        param_width;
	logic [v_width-1:0]        param_height;
	logic [size_width-1:0]     param_size;
	logic [axi_len_width-1:0]  param_arlen;
	frame_param_t              monitor_param;
	logic [axi_addr_width-1:0] araddr;
	logic [axi_len_width-1:0]  arlen;
	logic [2:0]                arsize;
	logic [1:0]                arburst;
	logic                      arvalid;
	logic                      arready;
	logic [axi_data_width-1:0] rdata;
	logic                      rlast;
	logic                      rvalid;
	logic                      rready;
	logic [axi_data_width-1:0] tdata;
	logic                      tlast;
	logic                      tuser;
	logic                      tvalid;
	logic                      tready;

	// expected stream beats as {data, last, user}
	logic [axi_data_width+1:0] expect_q [$];
	frame_param_t              applied;
	logic                      cur_packed;
	logic [31:0]               rng;
	logic [31:0]               ready_rng;
	int                        beats_seen;
	int                        beat_errors;
	int                        ar_errors;
	int                        ctl_errors;
	int                        timeouts;

	initial aclk = 1'b0;
	always #10 aclk = ~aclk;

	vdma_read_top uut (
		.aclk (aclk), .aresetn (aresetn),
		.ctl_enable (ctl_enable), .ctl_update (ctl_update),
		.ctl_busy (ctl_busy), .ctl_index (ctl_index),
		.param_addr (param_addr), .param_stride (param_stride),
		.param_width (param_width), .param_height (param_height),
		.param_size (param_size), .param_arlen (param_arlen),
		.monitor_param (monitor_param),
		.m_axi_araddr (araddr), .m_axi_arlen (arlen), .m_axi_arsize (arsize),
		.m_axi_arburst (arburst), .m_axi_arvalid (arvalid), .m_axi_arready (arready),
		.m_axi_rdata (rdata), .m_axi_rlast (rlast), .m_axi_rvalid (rvalid),
		.m_axi_rready (rready),
		.m_axis_tdata (tdata), .m_axis_tlast (tlast), .m_axis_tuser (tuser),
		.m_axis_tvalid (tvalid), .m_axis_tready (tready)
	);

	axi4_read_mem_model #(
		.data_key (data_key)
	) u_mem (
		.aclk (aclk), .aresetn (aresetn),
		.araddr (araddr), .arlen (arlen), .arvalid (arvalid), .arready (arready),
		.rdata (rdata), .rlast (rlast), .rvalid (rvalid), .rready (rready)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic roll(input int n, output int v);
		rng = xorshift32(rng);
		v = int'(rng[15:0]) % n;
	endtask

	// ----------------------------------------------------------------------
	// stream sink and monitors
	// ----------------------------------------------------------------------
	always @(posedge aclk) begin
		ready_rng = xorshift32(ready_rng);
		tready <= aresetn && (ready_rng[5:4] != 2'b00);
	end

	always @(posedge aclk) begin
		logic [axi_data_width+1:0] want;
		if (aresetn && tvalid && tready) begin
			beats_seen <= beats_seen + 1;
			assert (expect_q.size() != 0) else begin
				$display("stream beat 0x%08h arrived when no beat was expected", tdata);
				beat_errors++;
			end
			if (expect_q.size() != 0) begin
				want = expect_q.pop_front();
				assert (tdata == want[axi_data_width+1:2]) else begin
					$display("** Error: m_axis_tdata = 0x%08h, expected 0x%08h",
						tdata, want[axi_data_width+1:2]);
					beat_errors++;
				end
				assert (tlast == want[1]) else begin
					$display("** Error: m_axis_tlast = 0x%h, expected 0x%h", tlast, want[1]);
					beat_errors++;
				end
				assert (tuser == want[0]) else begin
					$display("** Error: m_axis_tuser = 0x%h, expected 0x%h", tuser, want[0]);
					beat_errors++;
				end
			end
		end
	end

	// burst shape on every AR handshake
	always @(posedge aclk) begin
		logic [axi_addr_width-1:0] line_offset;
		logic [axi_addr_width-1:0] burst_end;
		if (aresetn && arvalid && arready) begin
			assert (arlen <= applied.arlen) else begin
				$display("** Error: m_axi_arlen = 0x%02h, expected at most 0x%02h",
					arlen, applied.arlen);
				ar_errors++;
			end
			assert (arsize == axi_arsize) else begin
				$display("** Error: m_axi_arsize = 0x%h, expected 0x%h", arsize, axi_arsize);
				ar_errors++;
			end
			assert (arburst == axi_burst_incr) else begin
				$display("** Error: m_axi_arburst = 0x%h, expected 0x%h",
					arburst, axi_burst_incr);
				ar_errors++;
			end
			if (!cur_packed) begin
				line_offset = (araddr - applied.addr) % axi_addr_width'(applied.stride);
				burst_end   = line_offset + ((axi_addr_width'(arlen) + 1) << axi_data_size);
				assert (burst_end <= (axi_addr_width'(applied.width) << pixel_size)) else begin
					$display("burst at 0x%08h with %0d beats runs past the end of its line",
						araddr, arlen + 1);
					ar_errors++;
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// run one frame with random geometry and wait until all its beats are out
	// ----------------------------------------------------------------------
	task automatic run_frame(input logic force_update);
		int                        upd, w, h, maxlen, pad, pick, bpl, total, i, cycles, goal;
		logic [axi_addr_width-1:0] addr;
		logic [axi_addr_width-1:0] beat_addr;
		logic                      last;
		logic [index_width-1:0]    index_before;
		roll(4, pick);
		upd = (force_update || pick != 0) ? 1 : 0;
		roll(8, w);
		w = 2 * (w + 1);
		roll(6, h);
		h = h + 1;
		roll(8, maxlen);
		roll(3, pick);
		roll(4, pad);
		pad = (pick == 0) ? 0 : 4 * (pad + 1);
		roll(4096, i);
		addr = 32'h1000_0000 + (32'(i) << 2);

		if (upd != 0) begin
			applied.addr   = addr;
			applied.stride = stride_width'((w << pixel_size) + pad);
			applied.width  = h_width'(w);
			applied.height = v_width'(h);
			applied.size   = size_width'(w * h);
			applied.arlen  = axi_len_width'(maxlen);
		end
		cur_packed = (applied.size != 0) &&
			((int'(applied.width) << pixel_size) == int'(applied.stride));

		// beats = pixels >> (bus size - pixel size)
		bpl   = int'(applied.width) >> (axi_data_size - pixel_size);
		total = cur_packed ? int'(applied.size) >> (axi_data_size - pixel_size)
			: bpl * int'(applied.height);
		goal  = beats_seen + total;
		for (i = 0; i < total; i++) begin
			if (cur_packed) begin
				beat_addr = applied.addr + (32'(i) << axi_data_size);
			end else begin
				beat_addr = applied.addr + 32'(i / bpl) * 32'(applied.stride)
					+ (32'(i % bpl) << axi_data_size);
			end
			last = (i % bpl == bpl - 1) || (i == total - 1);
			expect_q.push_back({beat_addr ^ data_key, last, i == 0});
		end

		// params on a reuse frame are noise that must be ignored
		index_before  = ctl_index;
		ctl_enable   <= 1'b1;
		ctl_update   <= upd[0];
		param_addr   <= addr;
		param_stride <= stride_width'((w << pixel_size) + pad);
		param_width  <= h_width'(w);
		param_height <= v_width'(h);
		param_size   <= size_width'(w * h);
		param_arlen  <= axi_len_width'(maxlen);
		@(posedge aclk);
		ctl_enable <= 1'b0;
		ctl_update <= 1'b0;
		@(posedge aclk);
		assert (ctl_busy) else begin
			$display("ctl_busy did not rise after the frame start");
			ctl_errors++;
		end
		assert (ctl_index == index_before + 1'b1) else begin
			$display("** Error: ctl_index = 0x%02h, expected 0x%02h",
				ctl_index, index_before + 1'b1);
			ctl_errors++;
		end
		assert (monitor_param == applied) else begin
			$display("** Error: monitor_param = 0x%h, expected 0x%h", monitor_param, applied);
			ctl_errors++;
		end

		cycles = 0;
		while (ctl_busy && cycles < wait_limit) begin
			@(posedge aclk);
			cycles++;
		end
		if (ctl_busy) begin
			$display("timed out waiting for ctl_busy to fall");
			timeouts++;
		end else begin
			// only the output stage may still hold beats
			assert (goal - beats_seen <= 2) else begin
				$display("ctl_busy fell with %0d beats not yet read from memory",
					goal - beats_seen);
				ctl_errors++;
			end
			cycles = 0;
			while (beats_seen < goal && cycles < wait_limit) begin
				@(posedge aclk);
				cycles++;
			end
			if (beats_seen < goal) begin
				$display("timed out waiting for %0d stream beats", goal - beats_seen);
				timeouts++;
			end
		end
	endtask

	initial begin
		int f;
		rng          = 32'd63;
		ready_rng    = xorshift32(32'd63);
		beats_seen   = 0;
		beat_errors  = 0;
		ar_errors    = 0;
		ctl_errors   = 0;
		timeouts     = 0;
		applied      = '0;
		cur_packed   = 1'b0;
		aresetn      = 1'b0;
		ctl_enable   = 1'b0;
		ctl_update   = 1'b0;
		param_addr   = '0;
		param_stride = '0;
		param_width  = '0;
		param_height = '0;
		param_size   = '0;
		param_arlen  = '0;
		tready       = 1'b0;

		repeat (5) @(posedge aclk);
		assert (!ctl_busy && ctl_index == '0 && !arvalid && !tvalid && !rready) else begin
			$display("outputs not idle in reset: busy %b index 0x%02h arvalid %b tvalid %b rready %b",
				ctl_busy, ctl_index, arvalid, tvalid, rready);
			ctl_errors++;
		end
		aresetn <= 1'b1;
		@(posedge aclk);

		for (f = 0; f < frame_count && timeouts == 0; f++) begin
			run_frame(f == 0);
		end
		// stray or repeated beats would show up here
		repeat (20) @(posedge aclk);

		$display("errors: beat %0d, burst %0d, control %0d, timeout %0d",
			beat_errors, ar_errors, ctl_errors, timeouts);
		if (beat_errors + ar_errors + ctl_errors + timeouts == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
common/vdma_axi_pkg.sv
common/vdma_frame_pkg.sv
common/vdma_ifs.sv
design/stream_skid_buffer.sv
vdma_read/vdma_read_control.sv
vdma_read/axi4_line_reader.sv
design/vdma_read_top.sv
bench/axi4_read_mem_model.sv
bench/tb_vdma_read.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_vdma_read \
	-f src.f -o tb_vdma_read || exit 1
./obj_dir/tb_vdma_read > sim.log 2>&1 || true
cat sim.log
grep -qx "Simulation completed successfully" sim.log && exit 0 || exit 1
